/* list.f */
+incdir+src
src/backend_pkg.sv
src/rename_stage.sv
src/int_rs.sv
src/phys_regfile.sv
src/reorder_buffer.sv
src/backend_top.sv
dv/backend_tb.sv

/* dv/backend_tb.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend_tb
import backend_pkg::*;
();

    localparam int NUM_RANDOM    = 500;
    localparam int NUM_CHAIN     = 40;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic    clk;
    logic    arst_n_i;
    logic    instr_valid_i;
    instr_t  instr_i;
    logic    instr_ready_o;
    logic    commit_valid_o;
    commit_t commit_o;

    logic [`BE_XLEN-1:0] arf [`BE_NUM_AREGS];
    commit_t             exp_q [$];
    int                  accept_count;
    int                  commit_count;
    logic                saw_stall;
    int                  seed_init;

    backend_top i_backend_top (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Checking helpers.
    //////////////////////////////////////////////////
    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("TB FAILED");
        $fatal(1, "Run aborted");
    endtask

    //////////////////////////////////////////////////
    // Architectural reference model.
    //////////////////////////////////////////////////
    function automatic logic [31:0] alu_model(input opcode_e op, input logic [31:0] a,
                                              input logic [31:0] b,
                                              input logic [15:0] imm);
        logic [31:0] imm_ext;
        imm_ext = {{16{imm[15]}}, imm};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: return a + imm_ext;
            default: return 32'd0;
        endcase
    endfunction

    task automatic apply_model(input instr_t ins);
        commit_t     exp;
        logic [31:0] res;
        res = alu_model(ins.opcode, arf[ins.rs1], arf[ins.rs2], ins.imm);
        // r0 keeps reading zero.
        if (ins.rd != '0)
            arf[ins.rd] = res;
        exp.rd    = ins.rd;
        exp.value = (ins.rd == '0) ? 32'd0 : res;
        exp_q.push_back(exp);
    endtask

    function automatic instr_t make_instr(input opcode_e op, input int rd, input int rs1,
                                          input int rs2, input logic [15:0] imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = areg_t'(rd);
        ins.rs1    = areg_t'(rs1);
        ins.rs2    = areg_t'(rs2);
        ins.imm    = imm;
        return ins;
    endfunction

    // Small register range keeps dependencies frequent; ADDI is weighted up.
    function automatic instr_t random_instr();
        int      sel;
        opcode_e op;
        sel = $urandom_range(0, 9);
        op  = (sel > 6) ? OP_ADDI : opcode_e'(sel);
        return make_instr(op, $urandom_range(0, 3), $urandom_range(0, 3),
                          $urandom_range(0, 3), 16'($urandom));
    endfunction

    //////////////////////////////////////////////////
    // Stimulus, called on a falling edge.
    //////////////////////////////////////////////////
    task automatic send_instr(input instr_t ins);
        int waited;
        waited        = 0;
        instr_valid_i = 1'b1;
        instr_i       = ins;
        #1;
        while (!instr_ready_o) begin
            saw_stall = 1'b1;
            if (waited >= READY_TIMEOUT) begin
                abort_run("Timed out waiting for instr_ready_o");
            end else begin
                waited++;
                @(negedge clk);
                #1;
            end
        end
        // Ready only depends on registered state, so the next rising edge accepts.
        apply_model(ins);
        @(negedge clk);
        instr_valid_i = 1'b0;
    endtask

    task automatic idle_cycle();
        instr_valid_i = 1'b0;
        @(negedge clk);
    endtask

    // Handshakes as the DUT sees them at the rising edge.
    always @(posedge clk) begin
        if (arst_n_i && instr_valid_i && instr_ready_o)
            accept_count++;
    end

    // Commits are registered and sampled away from the rising edge.
    always @(negedge clk) begin : commit_monitor
        commit_t exp;
        if (arst_n_i && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("A commit arrived with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                check_value("commit rd", 32'(commit_o.rd), 32'(exp.rd));
                check_value("commit value", commit_o.value, exp.value);
                commit_count++;
            end
        end
    end

    initial begin
        int drain_wait;
        seed_init     = $urandom(32'he425_8d1d);
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        accept_count  = 0;
        commit_count  = 0;
        saw_stall     = 1'b0;
        for (int i = 0; i < `BE_NUM_AREGS; i++) begin
            arf[i] = '0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        #1;
        check_value("commit_valid_o after reset", 32'(commit_valid_o), 32'd0);
        check_value("instr_ready_o after reset", 32'(instr_ready_o), 32'd1);

        // r0 writes commit zero and later reads of r0 stay zero.
        send_instr(make_instr(OP_ADDI, 2, 0, 0, 16'h0123));
        send_instr(make_instr(OP_ADDI, 0, 2, 0, 16'h0005));
        send_instr(make_instr(OP_ADD, 3, 0, 0, 16'h0000));
        send_instr(make_instr(OP_ADDI, 1, 0, 0, 16'hfff3));

        // Back to back chain through r1.
        for (int i = 0; i < NUM_CHAIN; i++) begin
            if (i % 5 == 4)
                send_instr(make_instr(opcode_e'($urandom_range(0, 5)), 1, 1, 2, 16'h0));
            else if (i % 2 == 0)
                send_instr(make_instr(OP_ADDI, 1, 1, 0, 16'($urandom)));
            else
                send_instr(make_instr(OP_ADD, 1, 1, 1, 16'h0));
        end

        ///////////////////////////////////////////////////
        // Random program with idle gaps and full bursts.
        ///////////////////////////////////////////////////
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if (i >= 200 && i < 400) begin
                send_instr(random_instr());
            end else begin
                if ($urandom_range(0, 3) == 0)
                    idle_cycle();
                send_instr(random_instr());
            end
        end

        drain_wait = 0;
        while (exp_q.size() != 0) begin
            if (drain_wait >= DRAIN_TIMEOUT) begin
                abort_run("Timed out draining outstanding commits");
            end else begin
                drain_wait++;
                @(negedge clk);
                #1;
            end
        end
        // Quiet window to catch stray commits.
        repeat (20) @(negedge clk);
        #1;

        check_value("input stall observed", 32'(saw_stall), 32'd1);
        check_value("commit count", 32'(commit_count), 32'(accept_count));
        if (exp_q.size() == 0 && commit_count == accept_count) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "Outstanding instructions after drain");
        end
    end

endmodule

/* src/backend_top.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend_top
import backend_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,

    input  logic    instr_valid_i,
    input  instr_t  instr_i,
    output logic    instr_ready_o,

    output logic    commit_valid_o,
    output commit_t commit_o
);

    logic                disp_valid;
    uop_t                disp_uop;
    areg_t               disp_rd;
    preg_t               disp_old_preg;
    rob_idx_t            rob_tail;
    logic                rob_not_full;
    logic                rs_not_full;
    logic                free_valid;
    preg_t               free_preg;
    preg_t               prf_addr_a;
    preg_t               prf_addr_b;
    logic [`BE_XLEN-1:0] prf_data_a;
    logic [`BE_XLEN-1:0] prf_data_b;
    cdb_t                cdb;

    rename_stage i_rename_stage (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .instr_ready_o   (instr_ready_o),
        .rob_not_full_i  (rob_not_full),
        .rob_tail_i      (rob_tail),
        .rs_not_full_i   (rs_not_full),
        .cdb_i           (cdb),
        .free_valid_i    (free_valid),
        .free_preg_i     (free_preg),
        .disp_valid_o    (disp_valid),
        .disp_uop_o      (disp_uop),
        .disp_rd_o       (disp_rd),
        .disp_old_preg_o (disp_old_preg)
    );

    int_rs i_int_rs (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .disp_valid_i    (disp_valid),
        .disp_uop_i      (disp_uop),
        .rs_not_full_o   (rs_not_full),
        .rd_addr_a_o     (prf_addr_a),
        .rd_addr_b_o     (prf_addr_b),
        .rd_data_a_i     (prf_data_a),
        .rd_data_b_i     (prf_data_b),
        .cdb_o           (cdb)
    );

    phys_regfile i_phys_regfile (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .rd_addr_a_i     (prf_addr_a),
        .rd_addr_b_i     (prf_addr_b),
        .rd_data_a_o     (prf_data_a),
        .rd_data_b_o     (prf_data_b),
        .cdb_i           (cdb)
    );

    reorder_buffer i_reorder_buffer (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .disp_valid_i    (disp_valid),
        .disp_rd_i       (disp_rd),
        .disp_prd_i      (disp_uop.prd),
        .disp_old_preg_i (disp_old_preg),
        .rob_tail_o      (rob_tail),
        .rob_not_full_o  (rob_not_full),
        .cdb_i           (cdb),
        .free_valid_o    (free_valid),
        .free_preg_o     (free_preg),
        .commit_valid_o  (commit_valid_o),
        .commit_o        (commit_o)
    );

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module reorder_buffer
import backend_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,

    input  logic     disp_valid_i,
    input  areg_t    disp_rd_i,
    input  preg_t    disp_prd_i,
    input  preg_t    disp_old_preg_i,
    output rob_idx_t rob_tail_o,
    output logic     rob_not_full_o,

    input  cdb_t     cdb_i,

    output logic     free_valid_o,
    output preg_t    free_preg_o,
    output logic     commit_valid_o,
    output commit_t  commit_o
);

    localparam int ROB_D = `BE_ROB_DEPTH;
    localparam int CNT_W = $clog2(ROB_D + 1);

    areg_t               rd_q   [ROB_D];
    preg_t               prd_q  [ROB_D];
    preg_t               old_q  [ROB_D];
    logic [`BE_XLEN-1:0] val_q  [ROB_D];
    logic [ROB_D-1:0]    done_q;
    preg_t               rmap_q [`BE_NUM_AREGS];
    rob_idx_t            head_q;
    rob_idx_t            tail_q;
    logic [CNT_W-1:0]    count_q;
    logic                retire;
    areg_t               head_rd;

    assign retire  = done_q[head_q];
    assign head_rd = rd_q[head_q];

    // Tail and level seen by rename include the dispatch in flight.
    assign rob_tail_o     = tail_q + rob_idx_t'(disp_valid_i);
    assign rob_not_full_o = disp_valid_i ? (count_q < ROB_D - 1) : (count_q < ROB_D);

    assign free_valid_o = retire && (head_rd != '0);
    assign free_preg_o  = old_q[head_q];

    //////////////////////////////////////////////////
    // Allocation, completion and in-order retirement.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BE_NUM_AREGS; i++) begin
                rmap_q[i] <= preg_t'(i);
            end
            done_q         <= '0;
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            if (disp_valid_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.rob_idx] <= 1'b1;
            end
            if (retire) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
                if (head_rd != '0)
                    rmap_q[head_rd] <= prd_q[head_q];
            end
            count_q        <= count_q + CNT_W'(disp_valid_i) - CNT_W'(retire);
            commit_valid_o <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            rd_q[tail_q]  <= disp_rd_i;
            prd_q[tail_q] <= disp_prd_i;
            old_q[tail_q] <= disp_old_preg_i;
        end
        if (cdb_i.valid) begin
            val_q[cdb_i.rob_idx] <= cdb_i.value;
        end
        if (retire) begin
            commit_o.rd    <= head_rd;
            commit_o.value <= (head_rd == '0) ? '0 : val_q[head_q];
        end
    end

    a_no_empty_retire: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire |-> count_q != '0);

    a_no_full_dispatch: assert property (@(posedge clk) disable iff (!arst_n_i)
        disp_valid_i |-> count_q < ROB_D);

    // The preg freed at retirement is the one the retirement map still holds.
    a_free_matches_rmap: assert property (@(posedge clk) disable iff (!arst_n_i)
        free_valid_o |-> free_preg_o == rmap_q[head_rd]);

endmodule

/* src/phys_regfile.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module phys_regfile
import backend_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n_i,

    input  preg_t               rd_addr_a_i,
    input  preg_t               rd_addr_b_i,
    output logic [`BE_XLEN-1:0] rd_data_a_o,
    output logic [`BE_XLEN-1:0] rd_data_b_o,

    input  cdb_t                cdb_i
);

    logic [`BE_XLEN-1:0] regs_q [`BE_NUM_PREGS];
    logic                wr_en;

    // Preg 0 backs r0 and stays zero.
    assign wr_en = cdb_i.valid && (cdb_i.prd != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BE_NUM_PREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[cdb_i.prd] <= cdb_i.value;
        end
    end

    assign rd_data_a_o = (wr_en && cdb_i.prd == rd_addr_a_i) ? cdb_i.value : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (wr_en && cdb_i.prd == rd_addr_b_i) ? cdb_i.value : regs_q[rd_addr_b_i];

endmodule

/* src/int_rs.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module int_rs
import backend_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n_i,

    input  logic                disp_valid_i,
    input  uop_t                disp_uop_i,
    output logic                rs_not_full_o,

    output preg_t               rd_addr_a_o,
    output preg_t               rd_addr_b_o,
    input  logic [`BE_XLEN-1:0] rd_data_a_i,
    input  logic [`BE_XLEN-1:0] rd_data_b_i,

    output cdb_t                cdb_o
);

    localparam int RS_D  = `BE_RS_DEPTH;
    localparam int IDX_W = $clog2(RS_D);
    localparam int CNT_W = $clog2(RS_D + 1);

    uop_t                ent_q [RS_D];
    uop_t                ent_d [RS_D];
    uop_t                new_uop;
    logic [CNT_W-1:0]    count_q;
    logic [CNT_W-1:0]    cnt_keep;
    logic                issue;
    logic [IDX_W-1:0]    sel_idx;
    uop_t                sel_uop;
    logic [`BE_XLEN-1:0] opnd_b;
    logic [`BE_XLEN-1:0] alu_res;
    cdb_t                cdb_q;
    logic                src_pending;

    function automatic uop_t wake(uop_t u, cdb_t c);
        uop_t r;
        r = u;
        if (c.valid && c.prd == u.prs1)
            r.rdy1 = 1'b1;
        if (c.valid && c.prd == u.prs2)
            r.rdy2 = 1'b1;
        return r;
    endfunction

    // A pending dispatch already takes a slot.
    assign rs_not_full_o = disp_valid_i ? (count_q < RS_D - 1) : (count_q < RS_D);

    //////////////////////////////////////////////////
    // Select. Entries are kept in age order, oldest at 0.
    //////////////////////////////////////////////////
    always_comb begin
        issue   = 1'b0;
        sel_idx = '0;
        for (int i = RS_D - 1; i >= 0; i--) begin
            if (CNT_W'(i) < count_q && ent_q[i].rdy1 && ent_q[i].rdy2) begin
                issue   = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_uop     = ent_q[sel_idx];
    assign rd_addr_a_o = sel_uop.prs1;
    assign rd_addr_b_o = sel_uop.prs2;
    assign new_uop     = wake(disp_uop_i, cdb_q);

    // Wakeup, collapse over the issued slot, then append.
    always_comb begin
        for (int i = 0; i < RS_D; i++) begin
            ent_d[i] = wake(ent_q[i], cdb_q);
        end
        if (issue) begin
            for (int i = 0; i < RS_D - 1; i++) begin
                if (IDX_W'(i) >= sel_idx)
                    ent_d[i] = ent_d[i + 1];
            end
        end
        cnt_keep = count_q - CNT_W'(issue);
        if (disp_valid_i)
            ent_d[cnt_keep[IDX_W-1:0]] = new_uop;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= cnt_keep + CNT_W'(disp_valid_i);
        end
    end

    always_ff @(posedge clk) begin
        ent_q <= ent_d;
    end

    //////////////////////////////////////////////////
    // ALU.
    //////////////////////////////////////////////////
    assign opnd_b = (sel_uop.opcode == OP_ADDI)
                    ? {{(`BE_XLEN-16){sel_uop.imm[15]}}, sel_uop.imm}
                    : rd_data_b_i;

    always_comb begin
        case (sel_uop.opcode)
            OP_ADD, OP_ADDI: alu_res = rd_data_a_i + opnd_b;
            OP_SUB:          alu_res = rd_data_a_i - opnd_b;
            OP_AND:          alu_res = rd_data_a_i & opnd_b;
            OP_OR:           alu_res = rd_data_a_i | opnd_b;
            OP_XOR:          alu_res = rd_data_a_i ^ opnd_b;
            OP_SLT:          alu_res = {{(`BE_XLEN-1){1'b0}},
                                        $signed(rd_data_a_i) < $signed(opnd_b)};
            default:         alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cdb_q <= '0;
        end else begin
            cdb_q.valid   <= issue;
            cdb_q.prd     <= sel_uop.prd;
            cdb_q.rob_idx <= sel_uop.rob_idx;
            cdb_q.value   <= alu_res;
        end
    end

    assign cdb_o = cdb_q;

    // A producer still waiting here has not broadcast its result yet.
    always_comb begin
        src_pending = 1'b0;
        for (int i = 0; i < RS_D; i++) begin
            if (CNT_W'(i) < count_q && ent_q[i].prd != '0) begin
                if (ent_q[i].prd == sel_uop.prs1)
                    src_pending = 1'b1;
                if (ent_q[i].prd == sel_uop.prs2 && sel_uop.opcode != OP_ADDI)
                    src_pending = 1'b1;
            end
        end
    end

    a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        issue |-> !src_pending);

    a_disp_has_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
        disp_valid_i |-> cnt_keep < RS_D);

endmodule

/* src/rename_stage.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module rename_stage
import backend_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,

    input  logic     instr_valid_i,
    input  instr_t   instr_i,
    output logic     instr_ready_o,

    input  logic     rob_not_full_i,
    input  rob_idx_t rob_tail_i,
    input  logic     rs_not_full_i,
    input  cdb_t     cdb_i,
    input  logic     free_valid_i,
    input  preg_t    free_preg_i,

    output logic     disp_valid_o,
    output uop_t     disp_uop_o,
    output areg_t    disp_rd_o,
    output preg_t    disp_old_preg_o
);

    localparam int FL_D  = `BE_NUM_PREGS - `BE_NUM_AREGS;
    localparam int FL_AW = $clog2(FL_D);
    localparam int FL_CW = $clog2(FL_D + 1);

    preg_t                    rat_q [`BE_NUM_AREGS];
    logic [`BE_NUM_PREGS-1:0] ready_q;
    preg_t                    fl_q [FL_D];
    logic [FL_AW-1:0]         fl_head_q;
    logic [FL_AW-1:0]         fl_tail_q;
    logic [FL_CW-1:0]         fl_count_q;
    logic                     accept;
    logic                     alloc;
    preg_t                    new_preg;
    uop_t                     uop;
    logic                     new_mapped;

    assign instr_ready_o = (fl_count_q != '0) && rob_not_full_i && rs_not_full_i;
    assign accept        = instr_valid_i && instr_ready_o;
    // r0 stays on preg 0 and is never renamed.
    assign alloc         = accept && (instr_i.rd != '0);
    assign new_preg      = fl_q[fl_head_q];

    //////////////////////////////////////////////////
    // Source lookup with same-cycle CDB wakeup.
    //////////////////////////////////////////////////
    always_comb begin
        uop.opcode  = instr_i.opcode;
        uop.prd     = (instr_i.rd != '0) ? new_preg : '0;
        uop.prs1    = rat_q[instr_i.rs1];
        uop.prs2    = rat_q[instr_i.rs2];
        uop.rdy1    = ready_q[uop.prs1] || (cdb_i.valid && cdb_i.prd == uop.prs1);
        uop.rdy2    = ready_q[uop.prs2] || (cdb_i.valid && cdb_i.prd == uop.prs2)
                      || (instr_i.opcode == OP_ADDI);
        uop.imm     = instr_i.imm;
        uop.rob_idx = rob_tail_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BE_NUM_AREGS; i++) begin
                rat_q[i] <= preg_t'(i);
            end
            for (int i = 0; i < FL_D; i++) begin
                fl_q[i] <= preg_t'(`BE_NUM_AREGS + i);
            end
            ready_q      <= '1;
            fl_head_q    <= '0;
            fl_tail_q    <= '0;
            fl_count_q   <= FL_CW'(FL_D);
            disp_valid_o <= 1'b0;
        end else begin
            if (cdb_i.valid) begin
                ready_q[cdb_i.prd] <= 1'b1;
            end
            if (alloc) begin
                rat_q[instr_i.rd] <= new_preg;
                ready_q[new_preg] <= 1'b0;
                fl_head_q         <= fl_head_q + 1'b1;
            end
            // Retired pregs go back at the tail.
            if (free_valid_i) begin
                fl_q[fl_tail_q] <= free_preg_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            fl_count_q   <= fl_count_q + FL_CW'(free_valid_i) - FL_CW'(alloc);
            disp_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp_uop_o      <= uop;
            disp_rd_o       <= instr_i.rd;
            disp_old_preg_o <= rat_q[instr_i.rd];
        end
    end

    // A preg popped from a list that still holds entries is never mapped.
    always_comb begin
        new_mapped = 1'b0;
        for (int i = 0; i < `BE_NUM_AREGS; i++) begin
            if (rat_q[i] == new_preg)
                new_mapped = 1'b1;
        end
    end

    a_fl_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        alloc |-> !new_mapped);

endmodule

/* src/backend_pkg.sv */
`include "backend_cfg.svh"

package backend_pkg;

    typedef logic [$clog2(`BE_NUM_AREGS)-1:0] areg_t;
    typedef logic [$clog2(`BE_NUM_PREGS)-1:0] preg_t;
    typedef logic [$clog2(`BE_ROB_DEPTH)-1:0] rob_idx_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLT  = 3'd5,
        OP_ADDI = 3'd6
    } opcode_e;

    // Decoded instruction from the queue.
    typedef struct packed {
        opcode_e            opcode;
        areg_t              rd;
        areg_t              rs1;
        areg_t              rs2;
        logic signed [15:0] imm;
    } instr_t;

    // Renamed instruction as held by the reservation station.
    typedef struct packed {
        opcode_e            opcode;
        preg_t              prd;
        preg_t              prs1;
        preg_t              prs2;
        logic               rdy1;
        logic               rdy2;
        logic signed [15:0] imm;
        rob_idx_t           rob_idx;
    } uop_t;

    typedef struct packed {
        logic                valid;
        preg_t               prd;
        rob_idx_t            rob_idx;
        logic [`BE_XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        areg_t               rd;
        logic [`BE_XLEN-1:0] value;
    } commit_t;

endpackage

/* src/backend_cfg.svh */
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// Register file sizes.
`define BE_NUM_AREGS 8
`define BE_NUM_PREGS 16

// Queue depths.
`define BE_ROB_DEPTH 8
`define BE_RS_DEPTH 4

// Data path width.
`define BE_XLEN 32

`endif
